//--- project.f
rtl/conv_pkg.sv
rtl/conv_ctrl.sv
rtl/row_window.sv
rtl/weight_buffer.sv
rtl/patch_mult.sv
rtl/conv_engine_top.sv
verif/conv_engine_chk.sv
verif/conv_engine_tb.sv

//--- rtl/conv_ctrl.sv
`default_nettype none

module conv_ctrl (
	input  wire               clk,
	input  wire               rst,
	input  wire conv_pkg::cmd_e i_cmd,
	output logic              o_hold,
	output logic              o_res_valid,
	output logic              o_finish
);

	conv_pkg::state_e state_q;
	conv_pkg::state_e state_d;
	logic [conv_pkg::VALID_LAT-1:0] valid_pipe;  // compute flag delay line

	always_comb begin
		state_d = state_q;
		case (state_q)
			conv_pkg::ST_WAIT: begin
				if (i_cmd == conv_pkg::CMD_START) begin
					state_d = conv_pkg::ST_COMPUTE;
				end else if (i_cmd == conv_pkg::CMD_END) begin
					state_d = conv_pkg::ST_FINISH;
				end
			end
			conv_pkg::ST_COMPUTE: begin
				if (i_cmd == conv_pkg::CMD_HOLD) begin
					state_d = conv_pkg::ST_WAIT;
				end else if (i_cmd == conv_pkg::CMD_END) begin
					state_d = conv_pkg::ST_FINISH;
				end
			end
			conv_pkg::ST_FINISH: begin
				state_d = conv_pkg::ST_FINISH;  // sticky until reset
			end
			default: begin
				state_d = conv_pkg::ST_WAIT;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q    <= conv_pkg::ST_WAIT;
			valid_pipe <= '0;
			o_hold     <= 1'b0;
		end else begin
			state_q <= state_d;
			// lines valid up with the two multiplier stages
			valid_pipe <= {valid_pipe[conv_pkg::VALID_LAT-2:0],
				state_q == conv_pkg::ST_COMPUTE};
			o_hold <= (i_cmd == conv_pkg::CMD_HOLD);  // any state
		end
	end

	assign o_res_valid = valid_pipe[conv_pkg::VALID_LAT-1];
	assign o_finish    = (state_q == conv_pkg::ST_FINISH);

endmodule

`default_nettype wire

//--- rtl/conv_engine_top.sv
`default_nettype none

module conv_engine_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire conv_pkg::cmd_e    i_cmd,
	input  wire conv_pkg::row_t    i_row,
	input  wire                    i_row_valid,
	input  wire conv_pkg::pad_e    i_pad,
	input  wire conv_pkg::row_t    i_wword,
	input  wire                    i_wword_valid,
	output wire conv_pkg::result_t o_result,
	output wire                    o_res_valid,
	output wire                    o_finish
);

	logic                  hold;     // CMD_HOLD seen last cycle
	conv_pkg::window_t     window;
	conv_pkg::weight_buf_u weights;

	conv_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.i_cmd       (i_cmd),
		.o_hold      (hold),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish)
	);

	row_window u_window (
		.clk         (clk),
		.rst         (rst),
		.i_row       (i_row),
		.i_row_valid (i_row_valid),
		.i_pad       (i_pad),
		.o_window    (window)
	);

	weight_buffer u_wbuf (
		.clk           (clk),
		.rst           (rst),
		.i_wword       (i_wword),
		.i_wword_valid (i_wword_valid),
		.i_hold        (hold),
		.o_weights     (weights)
	);

	// one multiplier block per column position
	for (genvar p = 0; p < conv_pkg::N_POS; p++) begin : u_pos
		patch_mult #(
			.POS (p)
		) u_mult (
			.clk       (clk),
			.rst       (rst),
			.i_window  (window),
			.i_weights (weights),
			.o_prods   (o_result[p])
		);
	end

endmodule

`default_nettype wire

//--- rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

	localparam int PIX_W     = 8;  // pixel and weight width
	localparam int ROW_PIX   = 8;  // pixels per input row
	localparam int K_DIM     = 3;  // kernel side
	localparam int K_TAPS    = 9;  // lanes per patch
	localparam int N_KERNEL  = 8;  // kernels held in the buffer
	localparam int N_POS     = 8;  // column positions
	localparam int W_WORDS   = 9;  // 64-bit load words per buffer fill
	localparam int VALID_LAT = 2;  // window to result depth

	typedef logic [PIX_W-1:0] pixel_t;

	typedef pixel_t [ROW_PIX-1:0] row_t;  // pixel n at bits 8n

	typedef struct packed {
		row_t row_a;  // oldest
		row_t row_b;
		row_t row_c;  // newest
	} window_t;

	typedef pixel_t [K_TAPS-1:0] kernel_t;  // lane j = 3*r + c

	// one storage, loaded as words and read as kernels
	typedef union packed {
		row_t [W_WORDS-1:0]     words;    // word n at bits 64n
		kernel_t [N_KERNEL-1:0] kernels;  // kernel k at bits 72k
	} weight_buf_u;

	typedef logic [K_TAPS-1:0][2*PIX_W-1:0] prod_t;  // lane j at bits 16j

	typedef prod_t [N_KERNEL-1:0] pos_result_t;  // one per kernel

	typedef pos_result_t [N_POS-1:0] result_t;  // one per position

	typedef enum logic [1:0] {
		CMD_END   = 2'd0,
		CMD_START = 2'd1,
		CMD_HOLD  = 2'd2,
		CMD_NONE  = 2'd3
	} cmd_e;

	typedef enum logic [1:0] {
		PAD_NONE  = 2'd0,
		PAD_RIGHT = 2'd1,
		PAD_LEFT  = 2'd2   // 3 decodes like PAD_NONE
	} pad_e;

	typedef enum logic [1:0] {
		ST_WAIT    = 2'd0,
		ST_COMPUTE = 2'd1,
		ST_FINISH  = 2'd2
	} state_e;

endpackage

`default_nettype wire

//--- rtl/patch_mult.sv
`default_nettype none

module patch_mult #(
	parameter int POS = 0  // column position, 0 to 7
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire conv_pkg::window_t     i_window,
	input  wire conv_pkg::weight_buf_u i_weights,
	output conv_pkg::pos_result_t      o_prods
);

	conv_pkg::row_t [conv_pkg::K_DIM-1:0]       win_rows;  // index 0 is row_a
	conv_pkg::kernel_t                          patch_d;
	conv_pkg::kernel_t                          patch_q;
	conv_pkg::kernel_t [conv_pkg::N_KERNEL-1:0] kern_q;
	conv_pkg::pos_result_t                      prod_q;

	assign win_rows = {i_window.row_c, i_window.row_b, i_window.row_a};

	// columns wrap, so positions 6 and 7 reach back to pixel 0
	always_comb begin
		for (int r = 0; r < conv_pkg::K_DIM; r++) begin
			for (int c = 0; c < conv_pkg::K_DIM; c++) begin
				patch_d[r*conv_pkg::K_DIM + c] =
					win_rows[r][(POS + c) % conv_pkg::ROW_PIX];
			end
		end
	end

	// stage 1: operands
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			patch_q <= '0;
			kern_q  <= '0;
		end else begin
			patch_q <= patch_d;
			kern_q  <= i_weights.kernels;
		end
	end

	// stage 2: 72 lane products, full 16 bits
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			prod_q <= '0;
		end else begin
			for (int k = 0; k < conv_pkg::N_KERNEL; k++) begin
				for (int j = 0; j < conv_pkg::K_TAPS; j++) begin
					prod_q[k][j] <= patch_q[j] * kern_q[k][j];  // unsigned
				end
			end
		end
	end

	assign o_prods = prod_q;

endmodule

`default_nettype wire

//--- rtl/row_window.sv
`default_nettype none

module row_window (
	input  wire                    clk,
	input  wire                    rst,
	input  wire conv_pkg::row_t    i_row,
	input  wire                    i_row_valid,
	input  wire conv_pkg::pad_e    i_pad,
	output conv_pkg::window_t      o_window
);

	conv_pkg::window_t window_q;
	logic              pad_right;
	logic              pad_left;
	logic              shift_en;
	conv_pkg::row_t    new_row;

	assign pad_right = (i_pad == conv_pkg::PAD_RIGHT);
	assign pad_left  = (i_pad == conv_pkg::PAD_LEFT);
	assign shift_en  = i_row_valid || pad_left;

	// left padding pushes an all-zero row
	assign new_row = i_row_valid ? i_row : '0;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			window_q <= '0;
		end else if (pad_right) begin
			window_q <= '0;  // clear wins over any shift
		end else if (shift_en) begin
			window_q.row_a <= window_q.row_b;
			window_q.row_b <= window_q.row_c;
			window_q.row_c <= new_row;
		end
	end

	assign o_window = window_q;

endmodule

`default_nettype wire

//--- rtl/weight_buffer.sv
`default_nettype none

module weight_buffer (
	input  wire                   clk,
	input  wire                   rst,
	input  wire conv_pkg::row_t   i_wword,
	input  wire                   i_wword_valid,
	input  wire                   i_hold,
	output conv_pkg::weight_buf_u o_weights
);

	conv_pkg::weight_buf_u                    buf_q;
	logic [$clog2(conv_pkg::W_WORDS+1)-1:0]   count_q;  // words loaded so far
	logic                                     full;
	logic                                     wr_en;

	assign full  = (count_q == conv_pkg::W_WORDS);
	assign wr_en = i_wword_valid && !full;  // extra words dropped

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			buf_q <= '0;
		end else if (wr_en) begin
			buf_q.words[count_q] <= i_wword;  // load view
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count_q <= '0;
		end else if (i_hold) begin
			count_q <= '0;  // next word lands in word 0
		end else if (wr_en) begin
			count_q <= count_q + 1'b1;
		end
	end

	// consumers read the kernel view of the same bits
	assign o_weights = buf_q;

endmodule

`default_nettype wire

//--- verif/conv_engine_chk.sv
`default_nettype none

module conv_engine_chk (
	input wire clk,
	input wire rst,
	input wire i_res_valid,
	input wire i_finish
);

	int fail_cnt = 0;  // failed assertions so far

	a_finish_sticky: assert property (@(posedge clk) disable iff (!rst)
		i_finish |=> i_finish)  // held until reset
		else begin
			$error("o_finish dropped while out of reset");
			fail_cnt++;
		end

	// two edges after finish rises the last compute flag has drained
	a_valid_after_finish: assert property (@(posedge clk) disable iff (!rst)
		$past(i_finish, 2) |-> !i_res_valid)
		else begin
			$error("o_res_valid high two cycles after o_finish rose");
			fail_cnt++;
		end

	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst) |-> (!i_res_valid && !i_finish) ##1 (!i_res_valid && !i_finish))
		else begin
			$error("result valid or finish high right after reset release");
			fail_cnt++;
		end

endmodule

bind conv_engine_top conv_engine_chk u_chk (
	.clk         (clk),
	.rst         (rst),
	.i_res_valid (o_res_valid),
	.i_finish    (o_finish)
);

`default_nettype wire

//--- verif/conv_engine_tb.sv
`default_nettype none

module conv_engine_tb;

	localparam int RST_CYCLES  = 10;
	localparam int STIM_CYCLES = 600;
	localparam int END_CYCLE   = 580;
	localparam int TIMEOUT_CYC = RST_CYCLES + STIM_CYCLES + 90;  // 700 with margin

	logic              clk;
	logic              rst;
	conv_pkg::cmd_e    i_cmd;
	conv_pkg::row_t    i_row;
	logic              i_row_valid;
	conv_pkg::pad_e    i_pad;
	conv_pkg::row_t    i_wword;
	logic              i_wword_valid;
	conv_pkg::result_t o_result;
	logic              o_res_valid;
	logic              o_finish;

	logic [15:0] lfsr;
	int          cyc_cnt = 0;
	int          burst_left;

	logic [63:0]      m_row_a;  // model window, oldest row
	logic [63:0]      m_row_b;
	logic [63:0]      m_row_c;
	logic [575:0]     m_wbuf;   // word n at bits 64n
	int               m_count;
	logic             m_hold;
	conv_pkg::state_e m_state;
	logic [9215:0]    exp_res_q[$];
	logic             exp_vld_q[$];

	conv_engine_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.i_cmd         (i_cmd),
		.i_row         (i_row),
		.i_row_valid   (i_row_valid),
		.i_pad         (i_pad),
		.i_wword       (i_wword),
		.i_wword_valid (i_wword_valid),
		.o_result      (o_result),
		.o_res_valid   (o_res_valid),
		.o_finish      (o_finish)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};  // one step per bit
		end
	endtask

	// all 576 products for one window and buffer snapshot
	function automatic logic [9215:0] window_products(input logic [63:0] ra,
		input logic [63:0] rb, input logic [63:0] rc, input logic [575:0] wb);
		logic [9215:0] res;
		logic [63:0]   rows [3];
		logic [7:0]    pix;
		logic [7:0]    wt;
		int            lane;
		rows[0] = ra;
		rows[1] = rb;
		rows[2] = rc;
		res = '0;
		for (int p = 0; p < 8; p++) begin
			for (int k = 0; k < 8; k++) begin
				for (int r = 0; r < 3; r++) begin
					for (int c = 0; c < 3; c++) begin
						lane = 3 * r + c;
						pix  = rows[r][8 * ((p + c) % 8) +: 8];  // column wrap
						wt   = wb[72 * k + 8 * lane +: 8];
						res[1152 * p + 144 * k + 16 * lane +: 16] = pix * wt;
					end
				end
			end
		end
		return res;
	endfunction

	task automatic check_val(input string name, input logic [143:0] expected,
		input logic [143:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic drive_inputs(input int cyc);
		logic [63:0] r;
		take_bits(2, r);
		i_row_valid = (r[1:0] != 2'b00);  // about 3/4
		take_bits(64, r);
		i_row = r;
		take_bits(5, r);
		case (r[4:0])
			5'd0:    i_pad = conv_pkg::PAD_RIGHT;
			5'd1:    i_pad = conv_pkg::PAD_LEFT;
			5'd2:    i_pad = conv_pkg::pad_e'(2'd3);  // decodes as none
			default: i_pad = conv_pkg::PAD_NONE;
		endcase
		if (burst_left == 0) begin
			take_bits(4, r);
			if (r[3:0] == 4'd0) begin
				take_bits(3, r);
				burst_left = 6 + r[2:0];  // 6 to 13 words, some overflow
			end
		end
		i_wword_valid = (burst_left > 0);
		if (burst_left > 0) begin
			burst_left--;
		end
		take_bits(64, r);
		i_wword = r;
		take_bits(5, r);
		if (cyc == END_CYCLE) begin
			i_cmd = conv_pkg::CMD_END;
		end else if (cyc == 20 || cyc == 170) begin
			i_cmd = conv_pkg::CMD_START;
		end else if (cyc == 150) begin
			i_cmd = conv_pkg::CMD_HOLD;
		end else if (r[4:0] == 5'd0) begin
			i_cmd = conv_pkg::CMD_START;
		end else if (r[4:0] == 5'd1) begin
			i_cmd = conv_pkg::CMD_HOLD;
		end else begin
			i_cmd = conv_pkg::CMD_NONE;
		end
	endtask

	// one rising edge of the reference model, inputs as sampled
	task automatic model_step();
		logic wr;
		wr = i_wword_valid && (m_count != 9);
		if (wr) begin
			m_wbuf[64 * m_count +: 64] = i_wword;
		end
		if (m_hold) begin
			m_count = 0;  // pulse from last cycle wins
		end else if (wr) begin
			m_count++;
		end
		m_hold = (i_cmd == conv_pkg::CMD_HOLD);
		if (i_pad == conv_pkg::PAD_RIGHT) begin
			m_row_a = '0;
			m_row_b = '0;
			m_row_c = '0;
		end else if (i_row_valid || i_pad == conv_pkg::PAD_LEFT) begin
			m_row_a = m_row_b;
			m_row_b = m_row_c;
			m_row_c = i_row_valid ? i_row : 64'd0;
		end
		case (m_state)
			conv_pkg::ST_WAIT: begin
				if (i_cmd == conv_pkg::CMD_START) begin
					m_state = conv_pkg::ST_COMPUTE;
				end else if (i_cmd == conv_pkg::CMD_END) begin
					m_state = conv_pkg::ST_FINISH;
				end
			end
			conv_pkg::ST_COMPUTE: begin
				if (i_cmd == conv_pkg::CMD_HOLD) begin
					m_state = conv_pkg::ST_WAIT;
				end else if (i_cmd == conv_pkg::CMD_END) begin
					m_state = conv_pkg::ST_FINISH;
				end
			end
			default: begin
			end
		endcase
		exp_res_q.push_back(window_products(m_row_a, m_row_b, m_row_c, m_wbuf));
		exp_vld_q.push_back(m_state == conv_pkg::ST_COMPUTE);
	endtask

	task automatic check_outputs();
		logic [9215:0] exp_res;
		logic          exp_vld;
		exp_res = exp_res_q.pop_front();  // state from two edges back
		exp_vld = exp_vld_q.pop_front();
		check_val("o_res_valid", exp_vld, o_res_valid);
		check_val("o_finish", m_state == conv_pkg::ST_FINISH, o_finish);
		for (int p = 0; p < 8; p++) begin
			for (int k = 0; k < 8; k++) begin
				check_val($sformatf("o_result[%0d][%0d]", p, k),
					exp_res[1152 * p + 144 * k +: 144], o_result[p][k]);
			end
		end
	endtask

	// the bound checker counts its own assertion failures
	task automatic check_assertions();
		if (u_dut.u_chk.fail_cnt != 0) begin
			$display("a concurrent assertion on the DUT outputs failed");
			$display("TEST FAIL");
			$fatal(1, "stopping at first assertion failure");
		end
	endtask

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC) begin
			$display("timeout: stimulus did not complete within %0d cycles", TIMEOUT_CYC);
			$display("TEST FAIL");
			$fatal(1, "run stopped by timeout");
		end
	end

	initial begin
		rst           = 1'b0;
		i_cmd         = conv_pkg::CMD_NONE;
		i_row         = '0;
		i_row_valid   = 1'b0;
		i_pad         = conv_pkg::PAD_NONE;
		i_wword       = '0;
		i_wword_valid = 1'b0;
		lfsr          = 16'd74;
		burst_left    = 0;
		m_row_a       = '0;
		m_row_b       = '0;
		m_row_c       = '0;
		m_wbuf        = '0;
		m_count       = 0;
		m_hold        = 1'b0;
		m_state       = conv_pkg::ST_WAIT;
		repeat (2) begin
			exp_res_q.push_back('0);  // pipeline holds reset values
			exp_vld_q.push_back(1'b0);
		end
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 1'b1;
		for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
			drive_inputs(cyc);
			@(posedge clk);
			#1;
			model_step();
			check_outputs();
			check_assertions();
			#1;
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
